// File: project.f
source/rdma_ctrl_pkg.sv
source/ap_ctrl.sv
source/wait_timer.sv
source/qp_config.sv
source/cmd_sequencer.sv
source/credit_sender.sv
source/rdma_ctrl_top.sv
verif/rdma_ctrl_checker.sv
verif/tb_rdma_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rdma control testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rdma_ctrl -f project.f -o sim_rdma_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_rdma_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: source/ap_ctrl.sv
/* kernel handshake with start edge detect, idle flag and run timer */
`default_nettype none

module ap_ctrl #(
  parameter int unsigned RUN_CYCLES = 3000
) (
  input  logic net_clk,
  input  logic areset,
  input  logic ap_start,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done
);

  localparam int unsigned RUN_W = $clog2(RUN_CYCLES + 1);

  logic             ap_start_q;
  logic [RUN_W-1:0] run_cnt;

  assign start_pulse = ap_start & ~ap_start_q;  // first cycle of ap_start

  always_ff @(posedge net_clk) begin
    if (areset) begin
      ap_start_q <= 1'b0;
      ap_idle    <= 1'b1;
    end else begin
      ap_start_q <= ap_start;
      if (ap_done) begin
        ap_idle <= 1'b1;
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end
    end
  end

  // counts started cycles, done is a single cycle pulse
  always_ff @(posedge net_clk) begin
    if (areset) begin
      run_cnt <= '0;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      if (run_cnt == RUN_W'(RUN_CYCLES)) begin
        run_cnt <= '0;
        ap_done <= 1'b1;
      end else if (ap_start) begin
        run_cnt <= run_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cmd_sequencer.sv
/* command sequencer fsm building qp context, connection context
   and tx metadata words for each kernel mode */
`default_nettype none

module cmd_sequencer import rdma_ctrl_pkg::*; #(
  parameter int unsigned IDLE_CYCLES = 20
) (
  input  logic            net_clk,
  input  logic            areset,
  input  logic            start_pulse,
  input  logic            ap_start,
  input  host_cfg_t       host_cfg,
  input  logic [IP_W-1:0] remote_ip,
  input  logic            qp_full,
  input  logic            conn_full,
  input  logic            meta_full,
  output logic            qp_push,
  output qp_ctx_t         qp_word,
  output logic            conn_push,
  output conn_ctx_t       conn_word,
  output logic            meta_push,
  output tx_meta_t        meta_word
);

  seq_state_e       state;
  logic             seq_done;      // blocks reissue until next start
  kernel_mode_e     mode;
  logic [GAP_W-1:0] gap;
  logic [GAP_W-1:0] timer_count;
  logic             timer_load;
  logic             timer_enable;
  logic             timer_expired;

  assign mode = kernel_mode_e'(host_cfg.debug[1:0]);
  assign gap  = (host_cfg.debug[15:4] == '0) ? GAP_W'(1) : host_cfg.debug[15:4];

  ////////////////////////////////////////////////////////////////////////////
  // push strobes and timer control

  assign qp_push   = (state == seq_qp) & ~qp_full;
  assign conn_push = (state == seq_conn) & ~conn_full;

  always_comb begin
    case (state)
      seq_meta, seq_rwr_read:       meta_push = ~meta_full;
      seq_rwr_write, seq_rwr_read2: meta_push = ~meta_full & timer_expired;
      default:                      meta_push = 1'b0;
    endcase
  end

  // start delay from idle, gap after every rwr push
  assign timer_load   = ((state == seq_idle) & ap_start & ~seq_done) |
                        (meta_push & (state != seq_meta));
  assign timer_count  = (state == seq_idle) ? GAP_W'(IDLE_CYCLES) : gap;
  assign timer_enable = (state != seq_wait) | ap_start;

  wait_timer i_wait_timer (
    .net_clk (net_clk),
    .areset  (areset),
    .clear   (start_pulse),
    .load    (timer_load),
    .count   (timer_count),
    .enable  (timer_enable),
    .expired (timer_expired)
  );

  ////////////////////////////////////////////////////////////////////////////
  // command words

  always_comb begin
    qp_word.state = qp_state_ready_recv;
    qp_word.rqpn  = host_cfg.rqpn;
    qp_word.rpsn  = host_cfg.rpsn;
    qp_word.lpsn  = host_cfg.lpsn;
    qp_word.rkey  = host_cfg.rkey;
    qp_word.vaddr = host_cfg.vaddr;
  end

  always_comb begin
    conn_word.lqpn      = host_cfg.lqpn[15:0];
    conn_word.rqpn      = host_cfg.rqpn;
    conn_word.remote_ip = remote_ip;          // already byte swapped
    conn_word.udp_port  = host_cfg.rudp;
  end

  always_comb begin
    meta_word.op    = op_read;
    meta_word.lqpn  = host_cfg.lqpn;
    meta_word.laddr = '0;
    meta_word.raddr = '0;
    meta_word.len   = host_cfg.len;
    case (state)
      seq_meta: begin
        meta_word.op    = rdma_op_e'(host_cfg.op);
        meta_word.laddr = host_cfg.laddr;
        meta_word.raddr = host_cfg.raddr;
      end
      seq_rwr_write: begin
        meta_word.op    = op_write;
        meta_word.laddr = rwr_laddr_write;
      end
      seq_rwr_read2: meta_word.laddr = rwr_laddr_read2;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // fsm

  always_ff @(posedge net_clk) begin
    if (areset || start_pulse) begin
      state    <= seq_idle;
      seq_done <= 1'b0;
    end else begin
      case (state)
        seq_idle: begin
          if (ap_start && !seq_done) begin
            state <= seq_wait;
          end
        end
        seq_wait: begin
          if (timer_expired) begin
            state <= seq_qp;
          end
        end
        seq_qp: begin
          if (qp_push) begin
            state <= seq_conn;
          end
        end
        seq_conn: begin
          if (conn_push) begin
            case (mode)
              mode_op:  state <= seq_meta;
              mode_rwr: state <= seq_rwr_read;
              default: begin            // none and reserved stop here
                state    <= seq_idle;
                seq_done <= 1'b1;
              end
            endcase
          end
        end
        seq_rwr_read: begin
          if (meta_push) begin
            state <= seq_rwr_write;
          end
        end
        seq_rwr_write: begin
          if (meta_push) begin
            state <= seq_rwr_read2;
          end
        end
        seq_meta, seq_rwr_read2: begin
          if (meta_push) begin
            state    <= seq_idle;
            seq_done <= 1'b1;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/credit_sender.sv
/* one-entry holding register with credit counter for a command channel */
`default_nettype none

module credit_sender #(
  parameter int unsigned CREDIT_INIT = 2,
  parameter type         payload_t   = logic [7:0]
) (
  input  logic     net_clk,
  input  logic     areset,
  input  logic     push,
  input  payload_t word,
  input  logic     credit,
  output logic     full,
  output logic     valid,
  output payload_t data
);

  localparam int unsigned CREDIT_W = $clog2(CREDIT_INIT + 1);

  logic [CREDIT_W-1:0] credits;

  // beat needs a held word and a credit
  assign valid = full & (credits != '0);

  always_ff @(posedge net_clk) begin
    if (areset) begin
      full <= 1'b0;
    end else if (push) begin
      full <= 1'b1;
    end else if (valid) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge net_clk) begin
    if (push && !full) begin
      data <= word;
    end
  end

  always_ff @(posedge net_clk) begin
    if (areset) begin
      credits <= CREDIT_W'(CREDIT_INIT);
    end else begin
      case ({credit, valid})
        2'b10:   credits <= credits + 1'b1;  // return only
        2'b01:   credits <= credits - 1'b1;  // beat only
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/qp_config.sv
/* local and remote ip registers captured on start, byte swapped,
   board number latch and station mac derivation */
`default_nettype none

module qp_config import rdma_ctrl_pkg::*; #(
  parameter logic [MAC_W-1:0] MAC_ADDRESS = 48'hE59D02350A00
) (
  input  logic             net_clk,
  input  logic             areset,
  input  logic             start_pulse,
  input  logic [IP_W-1:0]  lip,
  input  logic [IP_W-1:0]  rip,
  input  logic [1:0]       board,
  output logic [IP_W-1:0]  local_ip,
  output logic [IP_W-1:0]  remote_ip,
  output logic [MAC_W-1:0] mac_address
);

  logic [1:0] board_q;
  logic [3:0] mac_nibble;

  // low nibble of the first octet, wraps mod 16
  assign mac_nibble = MAC_ADDRESS[43:40] + {2'b00, board_q};

  always_ff @(posedge net_clk) begin
    if (areset) begin
      local_ip  <= local_ip_reset;
      remote_ip <= remote_ip_reset;
      board_q   <= 2'd0;
    end else if (start_pulse) begin
      local_ip  <= {<<8{lip}};  // host gives network byte order
      remote_ip <= {<<8{rip}};
      board_q   <= board;
    end
  end

  // follows the board latch by one cycle
  always_ff @(posedge net_clk) begin
    if (areset) begin
      mac_address <= MAC_ADDRESS;
    end else begin
      mac_address <= {MAC_ADDRESS[47:44], mac_nibble, MAC_ADDRESS[39:0]};
    end
  end

endmodule

`default_nettype wire

// File: source/rdma_ctrl_pkg.sv
/* field widths, opcode, mode and fsm enums, command structs
   and reset constants for the roce host control block */
`default_nettype none

package rdma_ctrl_pkg;

  // field widths
  localparam int QPN_W   = 24;
  localparam int PSN_W   = 24;
  localparam int VADDR_W = 48;
  localparam int IP_W    = 32;
  localparam int MAC_W   = 48;
  localparam int LEN_W   = 32;
  localparam int GAP_W   = 12;  // start delay and rwr gap counter

  localparam logic [2:0]         qp_state_ready_recv = 3'd2;
  localparam logic [IP_W-1:0]    local_ip_reset      = 32'hD1D4010B;
  localparam logic [IP_W-1:0]    remote_ip_reset     = 32'hD2D4010B;
  localparam logic [VADDR_W-1:0] rwr_laddr_write     = 48'h000000000200;
  localparam logic [VADDR_W-1:0] rwr_laddr_read2     = 48'h000000000100;

  typedef enum logic [2:0] {
    op_read      = 3'd0,
    op_write     = 3'd1,
    op_write_imm = 3'd2,
    op_send      = 3'd3,
    op_send_imm  = 3'd4
  } rdma_op_e;

  // kernel mode lives in debug[1:0]
  typedef enum logic [1:0] {
    mode_none = 2'd0,
    mode_rwr  = 2'd1,  // read, write, read test
    mode_op   = 2'd2,
    mode_rsvd = 2'd3
  } kernel_mode_e;

  typedef enum logic [2:0] {
    seq_idle,
    seq_wait,
    seq_qp,
    seq_conn,
    seq_meta,
    seq_rwr_read,
    seq_rwr_write,
    seq_rwr_read2
  } seq_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // host inputs and command words

  typedef struct packed {
    logic [PSN_W-1:0]   rpsn;
    logic [PSN_W-1:0]   lpsn;
    logic [QPN_W-1:0]   rqpn;
    logic [QPN_W-1:0]   lqpn;
    logic [IP_W-1:0]    rip;
    logic [IP_W-1:0]    lip;
    logic [15:0]        rudp;
    logic [VADDR_W-1:0] vaddr;
    logic [15:0]        rkey;
    logic [2:0]         op;
    logic [VADDR_W-1:0] raddr;
    logic [VADDR_W-1:0] laddr;
    logic [LEN_W-1:0]   len;
    logic [15:0]        debug;  // gap, board, mode from msb down
  } host_cfg_t;

  typedef struct packed {
    logic [2:0]         state;
    logic [QPN_W-1:0]   rqpn;
    logic [PSN_W-1:0]   rpsn;
    logic [PSN_W-1:0]   lpsn;
    logic [15:0]        rkey;
    logic [VADDR_W-1:0] vaddr;
  } qp_ctx_t;

  typedef struct packed {
    logic [15:0]      lqpn;
    logic [QPN_W-1:0] rqpn;
    logic [IP_W-1:0]  remote_ip;
    logic [15:0]      udp_port;
  } conn_ctx_t;

  typedef struct packed {
    rdma_op_e           op;
    logic [QPN_W-1:0]   lqpn;
    logic [VADDR_W-1:0] laddr;
    logic [VADDR_W-1:0] raddr;
    logic [LEN_W-1:0]   len;
  } tx_meta_t;

endpackage

`default_nettype wire

// File: source/rdma_ctrl_top.sv
/* top level of the roce host control block, handshake, address setup,
   command sequencer and three credit senders */
`default_nettype none

module rdma_ctrl_top import rdma_ctrl_pkg::*; #(
  parameter int unsigned      RUN_CYCLES  = 3000,
  parameter int unsigned      IDLE_CYCLES = 20,
  parameter int unsigned      CREDIT_INIT = 2,
  parameter logic [MAC_W-1:0] MAC_ADDRESS = 48'hE59D02350A00
) (
  input  logic             net_clk,
  input  logic             areset,
  input  logic             ap_start,
  input  host_cfg_t        host_cfg,
  input  logic             qp_credit,
  input  logic             conn_credit,
  input  logic             meta_credit,
  output logic             ap_idle,
  output logic             ap_done,
  output logic             qp_valid,
  output qp_ctx_t          qp_ctx,
  output logic             conn_valid,
  output conn_ctx_t        conn_ctx,
  output logic             meta_valid,
  output tx_meta_t         tx_meta,
  output logic [IP_W-1:0]  local_ip,
  output logic [MAC_W-1:0] mac_address
);

  logic            start_pulse;
  logic [IP_W-1:0] remote_ip;
  logic            qp_push;
  logic            conn_push;
  logic            meta_push;
  logic            qp_full;
  logic            conn_full;
  logic            meta_full;
  qp_ctx_t         qp_word;
  conn_ctx_t       conn_word;
  tx_meta_t        meta_word;

  ////////////////////////////////////////////////////////////////////////////
  // control path

  ap_ctrl #(.RUN_CYCLES(RUN_CYCLES)) i_ap_ctrl (
    .net_clk     (net_clk),
    .areset      (areset),
    .ap_start    (ap_start),
    .start_pulse (start_pulse),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done)
  );

  qp_config #(.MAC_ADDRESS(MAC_ADDRESS)) i_qp_config (
    .net_clk     (net_clk),
    .areset      (areset),
    .start_pulse (start_pulse),
    .lip         (host_cfg.lip),
    .rip         (host_cfg.rip),
    .board       (host_cfg.debug[3:2]),  // board number
    .local_ip    (local_ip),
    .remote_ip   (remote_ip),
    .mac_address (mac_address)
  );

  cmd_sequencer #(.IDLE_CYCLES(IDLE_CYCLES)) i_cmd_sequencer (
    .net_clk     (net_clk),
    .areset      (areset),
    .start_pulse (start_pulse),
    .ap_start    (ap_start),
    .host_cfg    (host_cfg),
    .remote_ip   (remote_ip),
    .qp_full     (qp_full),
    .conn_full   (conn_full),
    .meta_full   (meta_full),
    .qp_push     (qp_push),
    .qp_word     (qp_word),
    .conn_push   (conn_push),
    .conn_word   (conn_word),
    .meta_push   (meta_push),
    .meta_word   (meta_word)
  );

  ////////////////////////////////////////////////////////////////////////////
  // command channels

  credit_sender #(.CREDIT_INIT(CREDIT_INIT), .payload_t(qp_ctx_t)) i_qp_sender (
    .net_clk (net_clk),
    .areset  (areset),
    .push    (qp_push),
    .word    (qp_word),
    .credit  (qp_credit),
    .full    (qp_full),
    .valid   (qp_valid),
    .data    (qp_ctx)
  );

  credit_sender #(.CREDIT_INIT(CREDIT_INIT), .payload_t(conn_ctx_t)) i_conn_sender (
    .net_clk (net_clk),
    .areset  (areset),
    .push    (conn_push),
    .word    (conn_word),
    .credit  (conn_credit),
    .full    (conn_full),
    .valid   (conn_valid),
    .data    (conn_ctx)
  );

  credit_sender #(.CREDIT_INIT(CREDIT_INIT), .payload_t(tx_meta_t)) i_meta_sender (
    .net_clk (net_clk),
    .areset  (areset),
    .push    (meta_push),
    .word    (meta_word),
    .credit  (meta_credit),
    .full    (meta_full),
    .valid   (meta_valid),
    .data    (tx_meta)
  );

endmodule

`default_nettype wire

// File: source/wait_timer.sv
/* loadable down-counter for the start delay and the rwr gaps */
`default_nettype none

module wait_timer import rdma_ctrl_pkg::*; (
  input  logic             net_clk,
  input  logic             areset,
  input  logic             clear,
  input  logic             load,
  input  logic [GAP_W-1:0] count,
  input  logic             enable,
  output logic             expired
);

  logic [GAP_W-1:0] remain;
  logic             armed;   // set by load, quiet after clear

  always_ff @(posedge net_clk) begin
    if (areset || clear) begin
      remain <= '0;
      armed  <= 1'b0;
    end else if (load) begin
      remain <= count;
      armed  <= 1'b1;
    end else if (enable && remain != '0) begin
      remain <= remain - 1'b1;
    end
  end

  assign expired = armed & (remain == '0);

endmodule

`default_nettype wire

// File: verif/rdma_ctrl_checker.sv
/* checker with reference models for command words and addresses,
   expected queues, credit accounting and handshake checks */
`default_nettype none

module rdma_ctrl_checker import rdma_ctrl_pkg::*; #(
  parameter int unsigned      CREDIT_INIT = 2,
  parameter logic [MAC_W-1:0] MAC_ADDRESS = 48'hE59D02350A00
) (
  input  logic             net_clk,
  input  logic             areset,
  input  logic             ap_start,
  input  host_cfg_t        host_cfg,
  input  int               test_id,
  input  logic             qp_credit,
  input  logic             conn_credit,
  input  logic             meta_credit,
  input  logic             ap_idle,
  input  logic             ap_done,
  input  logic             qp_valid,
  input  qp_ctx_t          qp_ctx,
  input  logic             conn_valid,
  input  conn_ctx_t        conn_ctx,
  input  logic             meta_valid,
  input  tx_meta_t         tx_meta,
  input  logic [IP_W-1:0]  local_ip,
  input  logic [MAC_W-1:0] mac_address,
  output int               error_count,
  output int               beat_count
);

  logic      start_q;
  logic      done_q;
  logic      first_cycle;
  host_cfg_t run_cfg;
  int        sent [3];
  int        returned [3];
  int        n;
  qp_ctx_t   qp_exp [$];
  conn_ctx_t conn_exp [$];
  tx_meta_t  meta_exp [$];
  qp_ctx_t   qp_ref;
  conn_ctx_t conn_ref;
  tx_meta_t  meta_ref;
  logic [2:0] beat_v;
  logic [2:0] ret_v;

  ////////////////////////////////////////////////////////////////////////////
  // reference models

  function automatic logic [31:0] byte_swap(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  function automatic qp_ctx_t expected_qp(input host_cfg_t cfg);
    qp_ctx_t q;
    q.state = 3'd2;  // ready to receive
    q.rqpn  = cfg.rqpn;
    q.rpsn  = cfg.rpsn;
    q.lpsn  = cfg.lpsn;
    q.rkey  = cfg.rkey;
    q.vaddr = cfg.vaddr;
    return q;
  endfunction

  function automatic conn_ctx_t expected_conn(input host_cfg_t cfg);
    conn_ctx_t c;
    c.lqpn      = cfg.lqpn[15:0];
    c.rqpn      = cfg.rqpn;
    c.remote_ip = byte_swap(cfg.rip);
    c.udp_port  = cfg.rudp;
    return c;
  endfunction

  // idx picks the command within the rwr test
  function automatic tx_meta_t expected_meta(input host_cfg_t cfg, input int idx);
    tx_meta_t m;
    m.op    = op_read;
    m.lqpn  = cfg.lqpn;
    m.laddr = '0;
    m.raddr = '0;
    m.len   = cfg.len;
    if (cfg.debug[1:0] == 2'd2) begin
      m.op    = rdma_op_e'(cfg.op);
      m.laddr = cfg.laddr;
      m.raddr = cfg.raddr;
    end else if (idx == 1) begin
      m.op    = op_write;
      m.laddr = 48'h200;
    end else if (idx == 2) begin
      m.laddr = 48'h100;
    end
    return m;
  endfunction

  function automatic int meta_count(input host_cfg_t cfg);
    case (cfg.debug[1:0])
      2'd1:    return 3;
      2'd2:    return 1;
      default: return 0;  // contexts only
    endcase
  endfunction

  function automatic logic [MAC_W-1:0] expected_mac(input host_cfg_t cfg);
    logic [MAC_W-1:0] m;
    m = MAC_ADDRESS;
    m[43:40] = m[43:40] + {2'b00, cfg.debug[3:2]};  // wraps mod 16
    return m;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "mode_op";
      2:       return "mode_rwr";
      3:       return "mode_none";
      4:       return "held_credits";
      5:       return "mode_rsvd";
      6:       return "restart_new_cfg";
      default: return "after_reset";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reporting

  task automatic report_mismatch(input string what, input logic [159:0] expected,
                                 input logic [159:0] actual);
    error_count++;
    $display("MISMATCH %s %s expected %0h actual %0h", test_name(test_id), what,
             expected, actual);
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR in test %s: %s", test_name(test_id), msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process, samples on the rising edge

  always @(posedge net_clk) begin
    if (areset) begin
      start_q     = 1'b0;
      done_q      = 1'b0;
      first_cycle = 1'b1;
      error_count = 0;
      beat_count  = 0;
      for (int k = 0; k < 3; k++) begin
        sent[k]     = 0;
        returned[k] = 0;
      end
      qp_exp.delete();
      conn_exp.delete();
      meta_exp.delete();
    end else begin
      if (first_cycle) begin
        if (ap_idle !== 1'b1 || ap_done !== 1'b0)
          report_error("handshake not idle after reset");
        if ({qp_valid, conn_valid, meta_valid} !== 3'b000)
          report_error("command valid high after reset");
      end
      if (done_q && ap_idle !== 1'b1) report_error("ap_idle did not rise after ap_done");

      // new run, expectations from the host config
      if (ap_start && !start_q) begin
        if (qp_exp.size() != 0 || conn_exp.size() != 0 || meta_exp.size() != 0)
          report_error("commands of the previous run never arrived");
        qp_exp.delete();
        conn_exp.delete();
        meta_exp.delete();
        run_cfg = host_cfg;
        qp_exp.push_back(expected_qp(host_cfg));
        conn_exp.push_back(expected_conn(host_cfg));
        n = meta_count(host_cfg);
        for (int i = 0; i < n; i++) meta_exp.push_back(expected_meta(host_cfg, i));
      end

      if (qp_valid) begin
        beat_count++;
        if (qp_exp.size() == 0) begin
          report_error("unexpected queue-pair context beat");
        end else begin
          qp_ref = qp_exp.pop_front();
          if (qp_ctx !== qp_ref) report_mismatch("qp_ctx", 160'(qp_ref), 160'(qp_ctx));
        end
      end

      if (conn_valid) begin
        beat_count++;
        if (qp_exp.size() != 0) report_error("connection context before queue-pair context");
        if (conn_exp.size() == 0) begin
          report_error("unexpected connection context beat");
        end else begin
          conn_ref = conn_exp.pop_front();
          if (conn_ctx !== conn_ref)
            report_mismatch("conn_ctx", 160'(conn_ref), 160'(conn_ctx));
        end
      end

      if (meta_valid) begin
        beat_count++;
        if (conn_exp.size() != 0) report_error("metadata before connection context");
        if (meta_exp.size() == 0) begin
          report_error("unexpected metadata beat");
        end else begin
          meta_ref = meta_exp.pop_front();
          if (tx_meta !== meta_ref)
            report_mismatch("tx_meta", 160'(meta_ref), 160'(tx_meta));
        end
      end

      // outstanding beats per channel bounded by the credit pool
      beat_v = {meta_valid, conn_valid, qp_valid};
      ret_v  = {meta_credit, conn_credit, qp_credit};
      for (int k = 0; k < 3; k++) begin
        if (beat_v[k]) sent[k]++;
        if (ret_v[k]) returned[k]++;
        if (sent[k] - returned[k] > int'(CREDIT_INIT))
          report_error($sformatf("channel %0d sent beyond its credits", k));
      end

      if (ap_done) begin
        if (ap_idle !== 1'b0) report_error("ap_idle high during the run");
        if (qp_exp.size() != 0 || conn_exp.size() != 0 || meta_exp.size() != 0)
          report_error("commands missing at ap_done");
        if (local_ip !== byte_swap(run_cfg.lip))
          report_mismatch("local_ip", 160'(byte_swap(run_cfg.lip)), 160'(local_ip));
        if (mac_address !== expected_mac(run_cfg))
          report_mismatch("mac_address", 160'(expected_mac(run_cfg)), 160'(mac_address));
      end

      start_q     = ap_start;
      done_q      = ap_done;
      first_cycle = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_rdma_ctrl.sv
/* testbench top for the roce host control block, clock, reset,
   test sequence, random credit returns, dut and timeout */
`default_nettype none

module tb_rdma_ctrl import rdma_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned      RUN_CYCLES     = 3000;
  localparam int unsigned      IDLE_CYCLES    = 20;
  localparam int unsigned      CREDIT_INIT    = 2;
  localparam logic [MAC_W-1:0] MAC_ADDRESS    = 48'hE59D02350A00;
  localparam int               NUM_TESTS      = 6;
  localparam int               HOLD_CYCLES    = 200;  // credits withheld this long
  localparam int               TIMEOUT_CYCLES = 4 * RUN_CYCLES * NUM_TESTS + 2000;

  logic             net_clk;
  logic             areset;
  logic             ap_start;
  host_cfg_t        host_cfg;
  logic             credit_ret [3];  // qp, conn, meta
  logic             hold_credits;
  int               test_id;
  int               seed = 88844;
  int               received [3];
  int               returned [3];
  int               cycles = 0;
  int               error_count;
  int               beat_count;
  logic             ap_idle;
  logic             ap_done;
  logic             qp_valid;
  qp_ctx_t          qp_ctx;
  logic             conn_valid;
  conn_ctx_t        conn_ctx;
  logic             meta_valid;
  tx_meta_t         tx_meta;
  logic [IP_W-1:0]  local_ip;
  logic [MAC_W-1:0] mac_address;

  rdma_ctrl_top #(
    .RUN_CYCLES  (RUN_CYCLES),
    .IDLE_CYCLES (IDLE_CYCLES),
    .CREDIT_INIT (CREDIT_INIT),
    .MAC_ADDRESS (MAC_ADDRESS)
  ) i_rdma_ctrl_top (
    .net_clk     (net_clk),
    .areset      (areset),
    .ap_start    (ap_start),
    .host_cfg    (host_cfg),
    .qp_credit   (credit_ret[0]),
    .conn_credit (credit_ret[1]),
    .meta_credit (credit_ret[2]),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .qp_valid    (qp_valid),
    .qp_ctx      (qp_ctx),
    .conn_valid  (conn_valid),
    .conn_ctx    (conn_ctx),
    .meta_valid  (meta_valid),
    .tx_meta     (tx_meta),
    .local_ip    (local_ip),
    .mac_address (mac_address)
  );

  rdma_ctrl_checker #(
    .CREDIT_INIT (CREDIT_INIT),
    .MAC_ADDRESS (MAC_ADDRESS)
  ) i_checker (
    .net_clk     (net_clk),
    .areset      (areset),
    .ap_start    (ap_start),
    .host_cfg    (host_cfg),
    .test_id     (test_id),
    .qp_credit   (credit_ret[0]),
    .conn_credit (credit_ret[1]),
    .meta_credit (credit_ret[2]),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .qp_valid    (qp_valid),
    .qp_ctx      (qp_ctx),
    .conn_valid  (conn_valid),
    .conn_ctx    (conn_ctx),
    .meta_valid  (meta_valid),
    .tx_meta     (tx_meta),
    .local_ip    (local_ip),
    .mac_address (mac_address),
    .error_count (error_count),
    .beat_count  (beat_count)
  );

  initial begin
    net_clk = 1'b0;
    forever #10 net_clk = ~net_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers

  function automatic host_cfg_t build_cfg(input kernel_mode_e mode, input logic [1:0] board,
                                          input logic [11:0] gap);
    host_cfg_t cfg;
    cfg.rpsn  = 24'($random(seed));
    cfg.lpsn  = 24'($random(seed));
    cfg.rqpn  = 24'($random(seed));
    cfg.lqpn  = 24'($random(seed));
    cfg.rip   = 32'($random(seed));
    cfg.lip   = 32'($random(seed));
    cfg.rudp  = 16'($random(seed));
    cfg.vaddr = {16'($random(seed)), 32'($random(seed))};
    cfg.rkey  = 16'($random(seed));
    cfg.op    = 3'($unsigned($random(seed)) % 32'd5);  // legal opcodes only
    cfg.raddr = {16'($random(seed)), 32'($random(seed))};
    cfg.laddr = {16'($random(seed)), 32'($random(seed))};
    cfg.len   = 32'($random(seed));
    cfg.debug = {gap, board, mode};
    return cfg;
  endfunction

  // hands back one credit per received beat after 1 to 8 cycles
  task automatic return_credits(input int ch);
    int delay;
    forever begin
      if (!hold_credits && returned[ch] < received[ch]) begin
        delay = 1 + int'($unsigned($random(seed)) % 32'd8);
        repeat (delay) @(posedge net_clk);
        #2 credit_ret[ch] = 1'b1;
        @(posedge net_clk);
        #2 credit_ret[ch] = 1'b0;
        returned[ch]++;
      end else begin
        @(posedge net_clk);
        #2;
      end
    end
  endtask

  task automatic run_test(input int id, input host_cfg_t cfg, input bit hold);
    @(posedge net_clk);
    #2;
    test_id      = id;
    host_cfg     = cfg;
    hold_credits = hold;
    ap_start     = 1'b1;
    if (hold) begin
      repeat (HOLD_CYCLES) @(posedge net_clk);
      #2 hold_credits = 1'b0;
    end
    do begin
      @(posedge net_clk);
      #2;
    end while (!ap_done);
    ap_start = 1'b0;
    repeat (6) @(posedge net_clk);
  endtask

  always @(posedge net_clk) begin
    if (qp_valid) received[0]++;
    if (conn_valid) received[1]++;
    if (meta_valid) received[2]++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    areset       = 1'b1;
    ap_start     = 1'b0;
    host_cfg     = '0;
    hold_credits = 1'b0;
    test_id      = 0;
    for (int i = 0; i < 3; i++) begin
      credit_ret[i] = 1'b0;
      received[i]   = 0;
      returned[i]   = 0;
    end
    fork
      return_credits(0);
      return_credits(1);
      return_credits(2);
    join_none
    repeat (16) @(posedge net_clk);
    #2 areset = 1'b0;
    repeat (4) @(posedge net_clk);

    run_test(1, build_cfg(mode_op, 2'd1, 12'd0), 1'b0);
    run_test(2, build_cfg(mode_rwr, 2'd2, 12'd0), 1'b0);   // zero gap acts as 1
    run_test(3, build_cfg(mode_none, 2'd0, 12'd3), 1'b0);
    run_test(4, build_cfg(mode_rwr, 2'd3, 12'd7), 1'b1);
    run_test(5, build_cfg(mode_rsvd, 2'd1, 12'd0), 1'b0);
    run_test(6, build_cfg(mode_op, 2'd2, 12'd5), 1'b0);    // new addresses and board

    $display("checker: %0d beats compared, %0d errors", beat_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge net_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire
